// ==== rtl/periph_config.svh ====
/*
 * Build-time configuration of the peripheral subsystem
 * The slot field must sit directly above the register offset bits
 * Slot numbers must fit in the slot field, unused slots are unmapped
 * The synchronizer depth applies to GPIO pins and the slow clock alike
 */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// APB geometry
`define PERIPH_ADDR_WIDTH 12
`define PERIPH_DATA_WIDTH 32

// Number of GPIO pins, at most one data word
`define PERIPH_NGPIO 16

// Address bits that select a peripheral slot
`define PERIPH_SLOT_LSB 8
`define PERIPH_SLOT_MSB 11

// Slot map
`define PERIPH_SLOT_GPIO 0
`define PERIPH_SLOT_TIMER 1

`define PERIPH_SYNC_STAGES 2

`endif

// ==== rtl/apb_pkg.sv ====
/*
 * APB request and response types for the peripheral bus
 * No pready, all slaves answer without wait states
 * pslverr is only meaningful at the top level
 */
`include "periph_config.svh"

package apb_pkg;

    typedef logic [`PERIPH_DATA_WIDTH-1:0] word_t;
    typedef logic [`PERIPH_ADDR_WIDTH-1:0] addr_t;

    // Master to slave
    typedef struct packed {
        addr_t paddr;
        word_t pwdata;
        logic  pwrite;
        logic  psel;
        logic  penable;
    } apb_req_t;

    // Slave to master, combinational during the access cycle
    typedef struct packed {
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// ==== rtl/periph_pkg.sv ====
/*
 * Register map, timer control layout and event bit positions
 * Offsets are byte addresses inside a slot
 * Event bits not listed here are reserved and read as zero
 */
`include "periph_config.svh"

package periph_pkg;

    typedef logic [`PERIPH_SLOT_LSB-1:0] reg_offset_t;
    typedef logic [`PERIPH_NGPIO-1:0]    gpio_vec_t;

    typedef enum reg_offset_t {
        GPIO_DIR       = 'h00,
        GPIO_OUT       = 'h04,
        GPIO_IN        = 'h08,
        GPIO_INTEN     = 'h0C,
        GPIO_INTSTATUS = 'h10
    } gpio_reg_e;

    typedef enum reg_offset_t {
        TIMER_CTRL  = 'h00,
        TIMER_COUNT = 'h04,
        TIMER_CMP   = 'h08
    } timer_reg_e;

    // Bit 0 enables counting, bit 1 selects the reference tick
    typedef struct packed {
        logic use_ref;
        logic enable;
    } timer_ctrl_t;

    // Positions in fc_events_o
    localparam int unsigned EVT_TIMER    = 10;
    localparam int unsigned EVT_REF_EDGE = 14;
    localparam int unsigned EVT_GPIO     = 15;

endpackage

// ==== rtl/edge_detect.sv ====
/*
 * Multi-flop synchronizer with per-bit edge detection
 * The input is treated as independent bits, no bus coherency
 * rise_o and fall_o are one-cycle pulses derived from sync_o
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module edge_detect #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic reset_i,
    input  T     async_i,
    output T     sync_o,
    output T     rise_o,
    output T     fall_o
);

    T sync_q [`PERIPH_SYNC_STAGES];
    T prev_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `PERIPH_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            prev_q <= '0;
        end else begin
            sync_q[0] <= async_i;
            for (int i = 1; i < `PERIPH_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            prev_q <= sync_q[`PERIPH_SYNC_STAGES-1];
        end
    end

    assign sync_o = sync_q[`PERIPH_SYNC_STAGES-1];

    // Compare against the value of one cycle earlier
    assign rise_o = sync_o & ~prev_q;
    assign fall_o = ~sync_o & prev_q;

endmodule

// ==== rtl/periph_apb_demux.sv ====
/*
 * Slot decoder between the external APB port and the peripherals
 * Purely combinational, the slaves never stall
 * Unmapped slots answer with pslverr and zero data in the access cycle
 * and reach no slave
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_apb_demux (
    input  apb_pkg::apb_req_t req_i,
    output apb_pkg::apb_rsp_t rsp_o,
    output apb_pkg::apb_req_t gpio_req_o,
    input  apb_pkg::word_t    gpio_rdata_i,
    output apb_pkg::apb_req_t timer_req_o,
    input  apb_pkg::word_t    timer_rdata_i
);

    logic [`PERIPH_SLOT_MSB-`PERIPH_SLOT_LSB:0] slot;
    logic sel_gpio;
    logic sel_timer;

    assign slot      = req_i.paddr[`PERIPH_SLOT_MSB:`PERIPH_SLOT_LSB];
    assign sel_gpio  = (slot == `PERIPH_SLOT_GPIO);
    assign sel_timer = (slot == `PERIPH_SLOT_TIMER);

    //////////////////////////////////////////////////
    // Request fan-out
    //////////////////////////////////////////////////

    // Everything but psel is shared by all slaves
    always_comb begin
        gpio_req_o       = req_i;
        gpio_req_o.psel  = req_i.psel & sel_gpio;
        timer_req_o      = req_i;
        timer_req_o.psel = req_i.psel & sel_timer;
    end

    //////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////

    always_comb begin
        rsp_o.prdata  = '0;
        rsp_o.pslverr = 1'b0;
        if (sel_gpio) begin
            rsp_o.prdata = gpio_rdata_i;
        end else if (sel_timer) begin
            rsp_o.prdata = timer_rdata_i;
        end else begin
            rsp_o.pslverr = req_i.psel & req_i.penable;
        end
    end

endmodule

// ==== rtl/periph_gpio.sv ====
/*
 * GPIO block with direction, output, input and interrupt registers
 * Pins are synchronized to clk_i before they are read or edge-detected
 * Only rising edges raise interrupts
 * INTSTATUS is read-only and clears the bits it returns on a read
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_gpio (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  apb_pkg::apb_req_t    req_i,
    output apb_pkg::word_t       rdata_o,
    input  periph_pkg::gpio_vec_t gpio_in_i,
    output periph_pkg::gpio_vec_t gpio_out_o,
    output periph_pkg::gpio_vec_t gpio_dir_o,
    output logic                 gpio_irq_o
);

    periph_pkg::reg_offset_t offset;
    logic                    wr_en;
    logic                    status_rd;

    periph_pkg::gpio_vec_t dir_q;
    periph_pkg::gpio_vec_t out_q;
    periph_pkg::gpio_vec_t inten_q;
    periph_pkg::gpio_vec_t status_q;

    periph_pkg::gpio_vec_t pin_sync;
    periph_pkg::gpio_vec_t pin_rise;
    periph_pkg::gpio_vec_t status_set;
    periph_pkg::gpio_vec_t status_clr;

    edge_detect #(
        .T ( periph_pkg::gpio_vec_t )
    ) u_pin_sync (
        .clk_i   ( clk_i     ),
        .reset_i ( reset_i   ),
        .async_i ( gpio_in_i ),
        .sync_o  ( pin_sync  ),
        .rise_o  ( pin_rise  ),
        .fall_o  (           )
    );

    assign offset    = req_i.paddr[`PERIPH_SLOT_LSB-1:0];
    assign wr_en     = req_i.psel & req_i.penable & req_i.pwrite;
    assign status_rd = req_i.psel & req_i.penable & ~req_i.pwrite
                     & (offset == periph_pkg::GPIO_INTSTATUS);

    // A new edge in the clearing cycle wins over the clear
    assign status_set = pin_rise & inten_q;
    assign status_clr = status_rd ? status_q : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
        end else begin
            if (wr_en && offset == periph_pkg::GPIO_DIR) begin
                dir_q <= req_i.pwdata[`PERIPH_NGPIO-1:0];
            end
            if (wr_en && offset == periph_pkg::GPIO_OUT) begin
                out_q <= req_i.pwdata[`PERIPH_NGPIO-1:0];
            end
            if (wr_en && offset == periph_pkg::GPIO_INTEN) begin
                inten_q <= req_i.pwdata[`PERIPH_NGPIO-1:0];
            end
            status_q <= (status_q & ~status_clr) | status_set;
        end
    end

    // Read data is zero unless this slot is selected
    always_comb begin
        rdata_o = '0;
        if (req_i.psel) begin
            case (offset)
                periph_pkg::GPIO_DIR:       rdata_o[`PERIPH_NGPIO-1:0] = dir_q;
                periph_pkg::GPIO_OUT:       rdata_o[`PERIPH_NGPIO-1:0] = out_q;
                periph_pkg::GPIO_IN:        rdata_o[`PERIPH_NGPIO-1:0] = pin_sync;
                periph_pkg::GPIO_INTEN:     rdata_o[`PERIPH_NGPIO-1:0] = inten_q;
                periph_pkg::GPIO_INTSTATUS: rdata_o[`PERIPH_NGPIO-1:0] = status_q;
                default:                    rdata_o = '0;
            endcase
        end
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_irq_o = |status_q;

endmodule

// ==== rtl/periph_timer.sv ====
/*
 * Compare timer counting clk_i cycles or reference ticks
 * On a match COUNT wraps to zero and the interrupt pulses once,
 * so the period is CMP+1 ticks
 * A write to COUNT takes priority over counting and suppresses a match
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_timer (
    input  logic              clk_i,
    input  logic              reset_i,
    input  apb_pkg::apb_req_t req_i,
    output apb_pkg::word_t    rdata_o,
    input  logic              ref_tick_i,
    output logic              timer_irq_o
);

    periph_pkg::reg_offset_t offset;
    logic                    wr_en;
    logic                    count_wr;
    logic                    tick;
    logic                    match;

    periph_pkg::timer_ctrl_t ctrl_q;
    apb_pkg::word_t          count_q;
    apb_pkg::word_t          cmp_q;
    logic                    irq_q;

    assign offset   = req_i.paddr[`PERIPH_SLOT_LSB-1:0];
    assign wr_en    = req_i.psel & req_i.penable & req_i.pwrite;
    assign count_wr = wr_en & (offset == periph_pkg::TIMER_COUNT);

    // One count step per cycle or per reference rise
    assign tick  = ctrl_q.enable & (ctrl_q.use_ref ? ref_tick_i : 1'b1);
    assign match = tick & (count_q == cmp_q);

    //////////////////////////////////////////////////
    // Counter and registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q  <= '0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= match & ~count_wr;
            if (count_wr) begin
                count_q <= req_i.pwdata;
            end else if (match) begin
                count_q <= '0;
            end else if (tick) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en && offset == periph_pkg::TIMER_CTRL) begin
                ctrl_q <= req_i.pwdata[$bits(periph_pkg::timer_ctrl_t)-1:0];
            end
            if (wr_en && offset == periph_pkg::TIMER_CMP) begin
                cmp_q <= req_i.pwdata;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.psel) begin
            case (offset)
                periph_pkg::TIMER_CTRL:  rdata_o[$bits(ctrl_q)-1:0] = ctrl_q;
                periph_pkg::TIMER_COUNT: rdata_o = count_q;
                periph_pkg::TIMER_CMP:   rdata_o = cmp_q;
                default:                 rdata_o = '0;
            endcase
        end
    end

    assign timer_irq_o = irq_q;

endmodule

// ==== rtl/soc_periph_top.sv ====
/*
 * Peripheral subsystem top with GPIO and timer on one APB port
 * slow_clk_i is sampled by clk_i and must be much slower than it
 * fc_events_o carries only timer, reference edge and GPIO events
 */
`timescale 1ns/1ps

module soc_periph_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  slow_clk_i,
    input  apb_pkg::apb_req_t     apb_req_i,
    output apb_pkg::apb_rsp_t     apb_rsp_o,
    input  periph_pkg::gpio_vec_t gpio_in_i,
    output periph_pkg::gpio_vec_t gpio_out_o,
    output periph_pkg::gpio_vec_t gpio_dir_o,
    output logic [31:0]           fc_events_o
);

    apb_pkg::apb_req_t gpio_req;
    apb_pkg::apb_req_t timer_req;
    apb_pkg::word_t    gpio_rdata;
    apb_pkg::word_t    timer_rdata;

    logic gpio_irq;
    logic timer_irq;
    logic ref_rise;
    logic ref_fall;

    //////////////////////////////////////////////////
    // Bus
    //////////////////////////////////////////////////

    periph_apb_demux u_apb_demux (
        .req_i         ( apb_req_i   ),
        .rsp_o         ( apb_rsp_o   ),
        .gpio_req_o    ( gpio_req    ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_req_o   ( timer_req   ),
        .timer_rdata_i ( timer_rdata )
    );

    //////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////

    periph_gpio u_gpio (
        .clk_i      ( clk_i      ),
        .reset_i    ( reset_i    ),
        .req_i      ( gpio_req   ),
        .rdata_o    ( gpio_rdata ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_irq_o ( gpio_irq   )
    );

    periph_timer u_timer (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .req_i       ( timer_req   ),
        .rdata_o     ( timer_rdata ),
        .ref_tick_i  ( ref_rise    ),
        .timer_irq_o ( timer_irq   )
    );

    // Reference clock edges as clk_i pulses
    edge_detect #(
        .T ( logic )
    ) u_ref_sync (
        .clk_i   ( clk_i      ),
        .reset_i ( reset_i    ),
        .async_i ( slow_clk_i ),
        .sync_o  (            ),
        .rise_o  ( ref_rise   ),
        .fall_o  ( ref_fall   )
    );

    //////////////////////////////////////////////////
    // Event vector
    //////////////////////////////////////////////////

    always_comb begin
        fc_events_o = '0;
        fc_events_o[periph_pkg::EVT_TIMER]    = timer_irq;
        fc_events_o[periph_pkg::EVT_REF_EDGE] = ref_rise | ref_fall;
        fc_events_o[periph_pkg::EVT_GPIO]     = gpio_irq;
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Free-running testbench clock and synchronous reset
 * Reset is released on a falling edge after RESET_CYCLES rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 16
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// ==== dv/soc_periph_sva.sv ====
/*
 * Bus protocol and interrupt assertions bound to the subsystem top
 * Sampled on rising clk_i edges, disabled during reset
 * fail_count counts failed assertions for the testbench to poll
 */
`timescale 1ns/1ps

module soc_periph_sva (
    input logic              clk_i,
    input logic              reset_i,
    input apb_pkg::apb_req_t apb_req_i,
    input apb_pkg::apb_rsp_t apb_rsp_i,
    input logic              timer_irq_i
);

    int fail_count = 0;

    // The timer interrupt is a single-cycle pulse
    property timer_irq_single_p;
        @(posedge clk_i) disable iff (reset_i)
        timer_irq_i |=> !timer_irq_i;
    endproperty

    property slverr_in_access_p;
        @(posedge clk_i) disable iff (reset_i)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable);
    endproperty

    property penable_with_psel_p;
        @(posedge clk_i) disable iff (reset_i)
        apb_req_i.penable |-> apb_req_i.psel;
    endproperty

    timer_irq_single_a: assert property (timer_irq_single_p)
        else begin
            fail_count++;
            $error("timer_irq_o stayed high for two cycles");
        end

    slverr_in_access_a: assert property (slverr_in_access_p)
        else begin
            fail_count++;
            $error("pslverr raised outside an access cycle");
        end

    penable_with_psel_a: assert property (penable_with_psel_p)
        else begin
            fail_count++;
            $error("penable high without psel");
        end

endmodule

bind soc_periph_top soc_periph_sva u_soc_periph_sva (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .apb_req_i   ( apb_req_i ),
    .apb_rsp_i   ( apb_rsp_o ),
    .timer_irq_i ( timer_irq )
);

// ==== dv/soc_periph_tb.sv ====
/*
 * Top-level testbench for the peripheral subsystem
 * Inputs change on the falling edge, outputs are sampled mid-phase
 * Expected values come from a register model kept by the stimulus
 * Random values use a fixed seed, so every run is identical
 */
`timescale 1ns/1ps
`include "periph_config.svh"

module soc_periph_tb;

    localparam int HALF_NS      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int ROUNDS       = 8;
    localparam int TIMER_PULSES = 6;
    localparam int REF_EDGES    = 24;
    localparam int SLOW_HALF    = 10;
    // Longest path through each test, with a factor of three for margin
    localparam int TIMEOUT_CYCLES = 3 * (RESET_CYCLES + ROUNDS * 40 + TIMER_PULSES * 16 + 40
                                  + (REF_EDGES + 2) * SLOW_HALF + 40 + ROUNDS * 20 + 60);
    localparam logic [31:0] EVT_MASK = (32'd1 << periph_pkg::EVT_TIMER)
                                     | (32'd1 << periph_pkg::EVT_REF_EDGE)
                                     | (32'd1 << periph_pkg::EVT_GPIO);

    // Register state as the testbench expects it
    typedef struct packed {
        periph_pkg::gpio_vec_t   dir;
        periph_pkg::gpio_vec_t   out;
        periph_pkg::gpio_vec_t   inten;
        periph_pkg::gpio_vec_t   status;
        periph_pkg::gpio_vec_t   pins;
        periph_pkg::timer_ctrl_t ctrl;
        apb_pkg::word_t          count;
        apb_pkg::word_t          cmp;
    } model_t;

    typedef struct packed {
        apb_pkg::word_t        rdata;
        logic                  slverr;
        periph_pkg::gpio_vec_t out;
        periph_pkg::gpio_vec_t dir;
        logic                  gpio_evt;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  slow_clk = 1'b0;
    apb_pkg::apb_req_t     apb_req  = '0;
    apb_pkg::apb_rsp_t     apb_rsp;
    periph_pkg::gpio_vec_t gpio_in  = '0;
    periph_pkg::gpio_vec_t gpio_out;
    periph_pkg::gpio_vec_t gpio_dir;
    logic [31:0]           fc_events;

    model_t model     = '0;
    int     seed      = 32'h2482_6d1b;
    int     cycle     = 0;
    int     ref_rises = 0;

    tb_clock_gen #(
        .HALF_PERIOD_NS ( HALF_NS      ),
        .RESET_CYCLES   ( RESET_CYCLES )
    ) u_clock_gen (
        .clk_o   ( clk   ),
        .reset_o ( reset )
    );

    soc_periph_top u_soc_periph_top (
        .clk_i       ( clk       ),
        .reset_i     ( reset     ),
        .slow_clk_i  ( slow_clk  ),
        .apb_req_i   ( apb_req   ),
        .apb_rsp_o   ( apb_rsp   ),
        .gpio_in_i   ( gpio_in   ),
        .gpio_out_o  ( gpio_out  ),
        .gpio_dir_o  ( gpio_dir  ),
        .fc_events_o ( fc_events )
    );

    //////////////////////////////////////////////////
    // Reporting and reference
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    function automatic apb_pkg::addr_t make_addr(input int slot, input int offset);
        apb_pkg::addr_t a;
        a = '0;
        a[`PERIPH_SLOT_MSB:`PERIPH_SLOT_LSB] = slot[`PERIPH_SLOT_MSB-`PERIPH_SLOT_LSB:0];
        a[`PERIPH_SLOT_LSB-1:0] = offset[`PERIPH_SLOT_LSB-1:0];
        return a;
    endfunction

    function automatic expect_t expected_response(input model_t m, input apb_pkg::addr_t addr);
        expect_t                     e;
        int                          slot;
        logic [`PERIPH_SLOT_LSB-1:0] offset;
        e          = '0;
        slot       = addr[`PERIPH_SLOT_MSB:`PERIPH_SLOT_LSB];
        offset     = addr[`PERIPH_SLOT_LSB-1:0];
        e.out      = m.out;
        e.dir      = m.dir;
        e.gpio_evt = |m.status;
        if (slot == `PERIPH_SLOT_GPIO) begin
            case (offset)
                periph_pkg::GPIO_DIR:       e.rdata = m.dir;
                periph_pkg::GPIO_OUT:       e.rdata = m.out;
                periph_pkg::GPIO_IN:        e.rdata = m.pins;
                periph_pkg::GPIO_INTEN:     e.rdata = m.inten;
                periph_pkg::GPIO_INTSTATUS: e.rdata = m.status;
                default:                    e.rdata = '0;
            endcase
        end else if (slot == `PERIPH_SLOT_TIMER) begin
            case (offset)
                periph_pkg::TIMER_CTRL:  e.rdata = m.ctrl;
                periph_pkg::TIMER_COUNT: e.rdata = m.count;
                periph_pkg::TIMER_CMP:   e.rdata = m.cmp;
                default:                 e.rdata = '0;
            endcase
        end else begin
            e.slverr = 1'b1;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////
    // Bus and event helpers
    //////////////////////////////////////////////////

    // Setup and access cycle, response sampled in the middle of the access
    task automatic bus_access(input apb_pkg::addr_t addr, input logic write,
                              input apb_pkg::word_t wdata,
                              output apb_pkg::word_t rdata, output logic slverr);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = write;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(HALF_NS / 2);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_reg(input int slot, input int offset, input apb_pkg::word_t data);
        apb_pkg::word_t rdata;
        logic           slverr;
        expect_t        exp;
        exp = expected_response(model, make_addr(slot, offset));
        bus_access(make_addr(slot, offset), 1'b1, data, rdata, slverr);
        check_value("pslverr", slverr, exp.slverr);
        if (exp.slverr) begin
            check_value("prdata", rdata, '0);
        end
    endtask

    task automatic read_reg(input int slot, input int offset, input string name);
        apb_pkg::word_t rdata;
        logic           slverr;
        expect_t        exp;
        exp = expected_response(model, make_addr(slot, offset));
        bus_access(make_addr(slot, offset), 1'b0, '0, rdata, slverr);
        check_value(name, rdata, exp.rdata);
        check_value("pslverr", slverr, exp.slverr);
    endtask

    // Returns the cycle number of the next 0 to 1 change of one event bit
    task automatic wait_event_rise(input int bit_pos, input int max_cycles, output int stamp);
        int   waited;
        logic seen_low;
        waited   = 0;
        seen_low = 1'b0;
        stamp    = -1;
        while (stamp < 0) begin
            @(posedge clk);
            #(HALF_NS / 2);
            if (!fc_events[bit_pos]) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                stamp = cycle;
            end
            waited++;
            if (stamp < 0 && waited > max_cycles) begin
                report_failure($sformatf("No rising edge on fc_events_o[%0d] within %0d cycles",
                                         bit_pos, max_cycles));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Background processes
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always begin
        repeat (SLOW_HALF) @(negedge clk);
        slow_clk = ~slow_clk;
    end

    // Reference edge pulses that follow a rise of slow_clk
    always @(posedge clk) begin
        #(HALF_NS / 2);
        if (fc_events[periph_pkg::EVT_REF_EDGE] && slow_clk) begin
            ref_rises = ref_rises + 1;
        end
    end

    always @(negedge clk) begin
        expect_t exp;
        #(HALF_NS / 2);
        if (!reset) begin
            exp = expected_response(model, '0);
            check_value("gpio_out_o", gpio_out, exp.out);
            check_value("gpio_dir_o", gpio_dir, exp.dir);
            check_value("fc_events_o reserved bits", fc_events & ~EVT_MASK, '0);
            check_value("assertion failures", u_soc_periph_top.u_soc_periph_sva.fail_count, 0);
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int                      t_prev;
        int                      t_now;
        int                      base;
        apb_pkg::word_t          val;
        periph_pkg::gpio_vec_t   new_pins;
        periph_pkg::gpio_vec_t   rises;
        periph_pkg::timer_ctrl_t ctrl;
        expect_t                 exp;

        @(negedge reset);

        // GPIO direction and output
        repeat (ROUNDS) begin
            val = $random(seed);
            write_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_DIR, val);
            model.dir = val[`PERIPH_NGPIO-1:0];
            val = $random(seed);
            write_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_OUT, val);
            model.out = val[`PERIPH_NGPIO-1:0];
            read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_DIR, "DIR");
            read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_OUT, "OUT");
        end

        // GPIO inputs and interrupt status
        repeat (ROUNDS) begin
            val = $random(seed);
            write_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_INTEN, val);
            model.inten = val[`PERIPH_NGPIO-1:0];
            new_pins = $random(seed);
            rises    = new_pins & ~model.pins;
            gpio_in  = new_pins;
            repeat (`PERIPH_SYNC_STAGES + 2) @(negedge clk);
            model.pins   = new_pins;
            model.status = model.status | (rises & model.inten);
            exp = expected_response(model, '0);
            check_value("fc_events_o[15]", fc_events[periph_pkg::EVT_GPIO], exp.gpio_evt);
            read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_IN, "IN");
            read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_INTSTATUS, "INTSTATUS");
            model.status = '0;
            exp = expected_response(model, '0);
            check_value("fc_events_o[15]", fc_events[periph_pkg::EVT_GPIO], exp.gpio_evt);
        end

        // Timer counting clock cycles
        model.cmp = 2 + {$random(seed)} % 14;
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CMP, model.cmp);
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_COUNT, '0);
        ctrl.use_ref = 1'b0;
        ctrl.enable  = 1'b1;
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CTRL, ctrl);
        model.ctrl = ctrl;
        wait_event_rise(periph_pkg::EVT_TIMER, 2 * (model.cmp + 1) + 8, t_prev);
        repeat (TIMER_PULSES) begin
            wait_event_rise(periph_pkg::EVT_TIMER, 2 * (model.cmp + 1) + 8, t_now);
            check_value("timer interrupt period", t_now - t_prev, model.cmp + 1);
            t_prev = t_now;
        end
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CTRL, '0);
        model.ctrl = '0;

        // Timer counting reference rises, enabled right after a reference edge
        model.cmp = 2 + {$random(seed)} % 4;
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CMP, model.cmp);
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_COUNT, '0);
        wait_event_rise(periph_pkg::EVT_REF_EDGE, 4 * SLOW_HALF, t_now);
        ctrl.use_ref = 1'b1;
        ctrl.enable  = 1'b1;
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CTRL, ctrl);
        model.ctrl = ctrl;
        base = ref_rises;
        repeat (REF_EDGES) begin
            wait_event_rise(periph_pkg::EVT_REF_EDGE, 4 * SLOW_HALF, t_now);
        end
        @(negedge clk);
        // Reference events alternate between rises and falls of slow_clk
        check_value("reference rises", ref_rises - base, REF_EDGES / 2);
        model.count = (ref_rises - base) % (model.cmp + 1);
        read_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_COUNT, "COUNT");
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CTRL, '0);
        model.ctrl = '0;
        val = $random(seed);
        write_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_COUNT, val);
        model.count = val;

        // Unmapped slots, then every register read back unchanged
        repeat (ROUNDS) begin
            t_now = 2 + {$random(seed)} % 14;
            val   = $random(seed);
            if (val[0]) begin
                write_reg(t_now, val[7:0] & 8'hFC, $random(seed));
            end else begin
                read_reg(t_now, val[7:0] & 8'hFC, "unmapped prdata");
            end
        end
        read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_DIR, "DIR");
        read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_OUT, "OUT");
        read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_INTEN, "INTEN");
        read_reg(`PERIPH_SLOT_GPIO, periph_pkg::GPIO_INTSTATUS, "INTSTATUS");
        read_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CTRL, "CTRL");
        read_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_COUNT, "COUNT");
        read_reg(`PERIPH_SLOT_TIMER, periph_pkg::TIMER_CMP, "CMP");

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/apb_pkg.sv
rtl/periph_pkg.sv
rtl/edge_detect.sv
rtl/periph_apb_demux.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/soc_periph_top.sv
dv/tb_clock_gen.sv
dv/soc_periph_sva.sv
dv/soc_periph_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/apb_pkg.sv
      - rtl/periph_pkg.sv
      - rtl/edge_detect.sv
      - rtl/periph_apb_demux.sv
      - rtl/periph_gpio.sv
      - rtl/periph_timer.sv
      - rtl/soc_periph_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_clock_gen.sv
      - dv/soc_periph_sva.sv
      - dv/soc_periph_tb.sv
